/* source/sprite_pkg.sv */
package sprite_pkg;

  // horizontal raster, in pixel clocks
  localparam int H_DISPLAY = 256;
  localparam int H_FRONT = 7;
  localparam int H_SYNC = 23;
  localparam int H_BACK = 23;
  localparam int H_TOTAL = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;

  // vertical raster, in lines
  localparam int V_DISPLAY = 240;
  localparam int V_FRONT = 5;
  localparam int V_SYNC = 3;
  localparam int V_BACK = 14;
  localparam int V_TOTAL = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;

  // width of the raster position counters
  localparam int POS_W = 9;

  // drawn sprite size; 8 stored columns are mirrored to 16
  localparam int SPRITE_W = 16;
  localparam int SPRITE_H = 16;
  localparam int ROM_ROWS = 16;

  // car image, row 0 first, bit 0 is the leftmost drawn pixel
  localparam logic [0:ROM_ROWS-1][7:0] CAR_BITMAP = {
    8'h30, 8'h77, 8'hE6, 8'hFF,
    8'hE6, 8'h67, 8'h30, 8'h30,
    8'h30, 8'h70, 8'h60, 8'hE0,
    8'hEC, 8'hFC, 8'hCC, 8'h0C
  };

endpackage

/* source/video_timing.sv */
module video_timing
  import sprite_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  output logic [POS_W-1:0] hpos,
  output logic [POS_W-1:0] vpos,
  output logic             hsync,
  output logic             vsync,
  output logic             display_on,
  output logic             line_strobe,
  output logic             frame_strobe
);

  logic h_last;
  logic v_last;

  assign h_last = (hpos == POS_W'(H_TOTAL - 1));
  assign v_last = (vpos == POS_W'(V_TOTAL - 1));

  // pixel counter runs every clock, line counter steps on wrap
  always_ff @(posedge clk) begin
    if (rst) begin
      hpos <= '0;
      vpos <= '0;
    end else if (h_last) begin
      hpos <= '0;
      if (v_last) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + 1'b1;
      end
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  // sync windows sit after the front porch
  assign hsync = (hpos >= POS_W'(H_DISPLAY + H_FRONT)) &&
                 (hpos < POS_W'(H_DISPLAY + H_FRONT + H_SYNC));
  assign vsync = (vpos >= POS_W'(V_DISPLAY + V_FRONT)) &&
                 (vpos < POS_W'(V_DISPLAY + V_FRONT + V_SYNC));

  // strobes mark the first cycle of each sync pulse
  assign line_strobe = (hpos == POS_W'(H_DISPLAY + H_FRONT));
  assign frame_strobe = line_strobe && (vpos == POS_W'(V_DISPLAY + V_FRONT));

  assign display_on = (hpos < POS_W'(H_DISPLAY)) && (vpos < POS_W'(V_DISPLAY));

  // counters must never leave the frame
  a_pos_in_frame: assert property (
    @(posedge clk) disable iff (rst)
    (hpos < POS_W'(H_TOTAL)) && (vpos < POS_W'(V_TOTAL))
  );

endmodule

/* source/car_rom.sv */
module car_rom
  import sprite_pkg::*;
(
  input  logic       clk,
  input  logic [3:0] rom_row,
  output logic [7:0] rom_bits
);

  logic [7:0] rom [ROM_ROWS];

  // image contents are fixed at build time
  initial begin
    for (int i = 0; i < ROM_ROWS; i++) begin
      rom[i] = CAR_BITMAP[i];
    end
  end

  // one clock of read latency, the renderer latches on the following cycle
  always_ff @(posedge clk) begin
    rom_bits <= rom[rom_row];
  end

endmodule

/* source/sprite_renderer.sv */
module sprite_renderer
  import sprite_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       vstart,
  input  logic       hstart,
  input  logic       load,
  output logic [3:0] rom_row,
  input  logic [7:0] rom_bits,
  output logic       gfx
);

  logic       y_active;
  logic       x_active;
  logic       loading;
  logic [3:0] y_count;
  logic [3:0] x_count;
  logic [7:0] row_bits;
  logic       pixel;

  // rows are stored upside down, so the first fetch reads row 15
  assign rom_row = ~y_count;

  // left half walks bits 0..7, right half walks back 7..0
  assign pixel = row_bits[x_count[3] ? ~x_count[2:0] : x_count[2:0]];

  always_ff @(posedge clk) begin
    if (rst) begin
      y_active <= 1'b0;
      x_active <= 1'b0;
      loading <= 1'b0;
      y_count <= '0;
      x_count <= '0;
      gfx <= 1'b0;
    end else begin
      gfx <= 1'b0;
      if (y_active && load) begin
        // rom sees rom_row this cycle, data is back next cycle
        loading <= 1'b1;
      end else if (loading) begin
        loading <= 1'b0;
        y_count <= y_count + 1'b1;
      end else if (vstart) begin
        y_active <= 1'b1;
      end else if (hstart && y_active) begin
        x_active <= 1'b1;
      end else if (x_active && y_active) begin
        gfx <= pixel;
        x_count <= x_count + 1'b1;
        if (x_count == 4'(SPRITE_W - 1)) begin
          x_active <= 1'b0;
          // row count has wrapped after the last fetch
          if (y_count == '0) begin
            y_active <= 1'b0;
          end
        end
      end
    end
  end

  // row data only changes while no pixels are shifting out
  always_ff @(posedge clk) begin
    if (rst) begin
      row_bits <= '0;
    end else if (loading) begin
      row_bits <= rom_bits;
    end
  end

  a_x_needs_y: assert property (
    @(posedge clk) disable iff (rst)
    x_active |-> y_active
  );

  // a pixel can only be driven on the cycle after an active column
  a_gfx_quiet: assert property (
    @(posedge clk) disable iff (rst)
    !x_active |=> !gfx
  );

  a_load_single: assert property (
    @(posedge clk) disable iff (rst)
    loading |=> !loading
  );

endmodule

/* source/paddle_capture.sv */
module paddle_capture
  import sprite_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             line_strobe,
  input  logic             frame_strobe,
  input  logic [POS_W-1:0] vpos,
  input  logic             hpaddle,
  input  logic             vpaddle,
  output logic [7:0]       player_x,
  output logic [7:0]       player_y
);

  logic [7:0] shadow_x;
  logic [7:0] shadow_y;
  logic [7:0] next_x;
  logic [7:0] next_y;

  // comparators are active low, the trip line becomes the coordinate
  always_comb begin
    next_x = shadow_x;
    next_y = shadow_y;
    if (line_strobe && !hpaddle) begin
      next_x = vpos[7:0];
    end
    if (line_strobe && !vpaddle) begin
      next_y = vpos[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      shadow_x <= '0;
      shadow_y <= '0;
      player_x <= '0;
      player_y <= '0;
    end else begin
      shadow_x <= next_x;
      shadow_y <= next_y;
      // commit both together during vertical sync
      if (frame_strobe) begin
        player_x <= next_x;
        player_y <= next_y;
      end
    end
  end

endmodule

/* source/sprite_display_top.sv */
module sprite_display_top
  import sprite_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             hpaddle,
  input  logic             vpaddle,
  output logic             hsync,
  output logic             vsync,
  output logic             display_on,
  output logic [POS_W-1:0] hpos,
  output logic [POS_W-1:0] vpos,
  output logic [2:0]       rgb
);

  logic       line_strobe;
  logic       frame_strobe;
  logic [7:0] player_x;
  logic [7:0] player_y;
  logic       vstart;
  logic       hstart;
  logic [3:0] rom_row;
  logic [7:0] rom_bits;
  logic       gfx;

  video_timing u_video_timing (
    .clk          (clk),
    .rst          (rst),
    .hpos         (hpos),
    .vpos         (vpos),
    .hsync        (hsync),
    .vsync        (vsync),
    .display_on   (display_on),
    .line_strobe  (line_strobe),
    .frame_strobe (frame_strobe)
  );

  paddle_capture u_paddle_capture (
    .clk          (clk),
    .rst          (rst),
    .line_strobe  (line_strobe),
    .frame_strobe (frame_strobe),
    .vpos         (vpos),
    .hpaddle      (hpaddle),
    .vpaddle      (vpaddle),
    .player_x     (player_x),
    .player_y     (player_y)
  );

  // start compares against the raster position
  assign vstart = ({1'b0, player_y} == vpos);
  assign hstart = ({1'b0, player_x} == hpos);

  car_rom u_car_rom (
    .clk      (clk),
    .rom_row  (rom_row),
    .rom_bits (rom_bits)
  );

  sprite_renderer u_sprite_renderer (
    .clk      (clk),
    .rst      (rst),
    .vstart   (vstart),
    .hstart   (hstart),
    .load     (line_strobe),
    .rom_row  (rom_row),
    .rom_bits (rom_bits),
    .gfx      (gfx)
  );

  // monochrome sprite, all channels on together
  assign rgb = {3{display_on & gfx}};

endmodule

/* dv/sprite_tb.sv */
module sprite_tb
  import sprite_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 4;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int N_ENTRIES = 6;
  // one settle frame after reset, two frames per entry, one spare
  localparam int TIMEOUT_CYCLES = (2 * N_ENTRIES + 2) * FRAME_CYCLES;

  // trip lines for hpaddle and vpaddle, whether they are pulled, resulting position
  localparam int X_LINE [N_ENTRIES] = '{40, 0, 230, 128, 0, 100};
  localparam int Y_LINE [N_ENTRIES] = '{60, 0, 200, 223, 0, 100};
  localparam bit PULL [N_ENTRIES] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
  localparam int EXP_X [N_ENTRIES] = '{40, 0, 230, 128, 128, 100};
  localparam int EXP_Y [N_ENTRIES] = '{60, 0, 200, 223, 223, 100};

  logic             clk;
  logic             rst;
  logic             hpaddle;
  logic             vpaddle;
  logic             hsync;
  logic             vsync;
  logic             display_on;
  logic [POS_W-1:0] hpos;
  logic [POS_W-1:0] vpos;
  logic [2:0]       rgb;

  int mismatch_count;
  int check_count;
  int cycle_count;

  sprite_display_top u_sprite_display_top (
    .clk        (clk),
    .rst        (rst),
    .hpaddle    (hpaddle),
    .vpaddle    (vpaddle),
    .hsync      (hsync),
    .vsync      (vsync),
    .display_on (display_on),
    .hpos       (hpos),
    .vpos       (vpos),
    .rgb        (rgb)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // reference pixel from the raster position and the sprite position
  function automatic logic [2:0] expected_rgb(input int h, input int v, input int px,
                                              input int py);
    int         r;
    int         k;
    logic [7:0] row;
    logic       bit_on;
    r = v - py - 1;
    k = h - px - 2;
    bit_on = 1'b0;
    if (h < H_DISPLAY && v < V_DISPLAY && r >= 0 && r < SPRITE_H && k >= 0 &&
        k < SPRITE_W) begin
      // first drawn line shows the last stored row
      row = CAR_BITMAP[4'(ROM_ROWS - 1 - r)];
      // right half mirrors the left half
      bit_on = (k < 8) ? row[3'(k)] : row[3'(SPRITE_W - 1 - k)];
    end
    return {3{bit_on}};
  endfunction

  task automatic report_mismatch(input string what, input int expected, input int actual);
    mismatch_count++;
    $display("mismatch at %0t: %s at hpos=%0d vpos=%0d, expected %0d, got %0d",
             $time, what, hpos, vpos, expected, actual);
  endtask

  // sync and colour outputs stay low while in reset
  task automatic check_quiet();
    check_count++;
    assert (hsync === 1'b0) else report_mismatch("hsync in reset", 0, int'(hsync));
    assert (vsync === 1'b0) else report_mismatch("vsync in reset", 0, int'(vsync));
    assert (rgb === 3'b000) else report_mismatch("rgb in reset", 0, int'(rgb));
  endtask

  // h and v are where the raster should be in the cycle just ended
  task automatic check_cycle(input int h, input int v, input int px, input int py);
    logic       exp_hsync;
    logic       exp_vsync;
    logic       exp_display;
    logic [2:0] exp_rgb;
    exp_hsync = (h >= H_DISPLAY + H_FRONT) && (h < H_DISPLAY + H_FRONT + H_SYNC);
    exp_vsync = (v >= V_DISPLAY + V_FRONT) && (v < V_DISPLAY + V_FRONT + V_SYNC);
    exp_display = (h < H_DISPLAY) && (v < V_DISPLAY);
    exp_rgb = expected_rgb(h, v, px, py);
    check_count++;
    assert (int'(hpos) == h) else report_mismatch("hpos", h, int'(hpos));
    assert (int'(vpos) == v) else report_mismatch("vpos", v, int'(vpos));
    assert (hsync === exp_hsync) else report_mismatch("hsync", int'(exp_hsync), int'(hsync));
    assert (vsync === exp_vsync) else report_mismatch("vsync", int'(exp_vsync), int'(vsync));
    assert (display_on === exp_display) else begin
      report_mismatch("display_on", int'(exp_display), int'(display_on));
    end
    assert (display_on || rgb == 3'b000) else report_mismatch("rgb while blanked", 0, int'(rgb));
    assert (rgb === exp_rgb) else report_mismatch("rgb", int'(exp_rgb), int'(rgb));
  endtask

  // returns when the next cycle is the first one of a frame
  task automatic wait_frame_end();
    do begin
      @(posedge clk);
    end while (!(int'(hpos) == H_TOTAL - 1 && int'(vpos) == V_TOTAL - 1));
  endtask

  // one full frame, checked against the position shown in it
  task automatic run_frame(input bit pull, input int x_line, input int y_line, input int px,
                           input int py);
    int h;
    int v;
    for (int n = 0; n < FRAME_CYCLES; n++) begin
      @(posedge clk);
      h = n % H_TOTAL;
      v = n / H_TOTAL;
      check_cycle(h, v, px, py);
      // low one cycle behind the trip line, so its line_strobe sees it
      hpaddle <= !(pull && v == x_line);
      vpaddle <= !(pull && v == y_line);
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: test did not finish after %0d cycles", cycle_count);
    $display("checks: %0d, mismatches: %0d", check_count, mismatch_count);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [2:0] idx;
    int         shown_x;
    int         shown_y;
    rst = 1'b1;
    hpaddle = 1'b1;
    vpaddle = 1'b1;
    mismatch_count = 0;
    check_count = 0;

    // outputs are only defined from the first reset edge on
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      if (c > 0) begin
        check_quiet();
      end
    end
    rst <= 1'b0;
    @(posedge clk);
    check_quiet();
    wait_frame_end();

    // reset leaves the sprite at the origin
    shown_x = 0;
    shown_y = 0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      idx = 3'(i);
      // capture frame still shows the old position
      run_frame(PULL[idx], X_LINE[idx], Y_LINE[idx], shown_x, shown_y);
      shown_x = EXP_X[idx];
      shown_y = EXP_Y[idx];
      run_frame(1'b0, 0, 0, shown_x, shown_y);
    end

    $display("checks: %0d, mismatches: %0d", check_count, mismatch_count);
    if (mismatch_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* verilog.f */
source/sprite_pkg.sv
source/video_timing.sv
source/car_rom.sv
source/sprite_renderer.sv
source/paddle_capture.sv
source/sprite_display_top.sv
dv/sprite_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the sprite display testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module sprite_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_output=$(./obj_dir/Vsprite_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
